// File: verilog.f
+incdir+verification
source/dbg_pkg.sv
source/access_timer.sv
source/sba_fsm.sv
source/word_mem.sv
source/sba_regs.sv
source/dbg_sba_top.sv
verification/tb_dbg_sba.sv

// File: Bender.yml
package:
  name: dbg_sba

sources:
  - source/dbg_pkg.sv
  - source/access_timer.sv
  - source/sba_fsm.sv
  - source/word_mem.sv
  - source/sba_regs.sv
  - source/dbg_sba_top.sv
  - target: simulation
    include_dirs:
      - verification
    files:
      - verification/tb_dbg_sba.sv

// File: verification/tb_dbg_tasks.svh
/*
 * DMI access tasks and directed tests for the access port testbench.
 * Included inside the testbench module; uses its signals and models.
 */

//////////////////////////////////////////////////////////////////////
// DMI access
//////////////////////////////////////////////////////////////////////

task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                           input string what);
  checks_run++;
  assert (got === exp) else begin
    check_errors++;
    $display("FAIL %0t: %s, got %h expected %h", $time, what, got, exp);
  end
endtask

task automatic drive_request(input logic write, input logic [6:0] addr,
                             input logic [31:0] data);
  @(posedge clk);
  dmi_req_valid_i <= 1'b1;
  dmi_write_i     <= write;
  dmi_addr_i      <= addr;
  dmi_wdata_i     <= data;
endtask

task automatic drive_idle();
  @(posedge clk);
  dmi_req_valid_i <= 1'b0;
  dmi_write_i     <= 1'b0;
  dmi_wdata_i     <= '0;
endtask

// Sampled on the falling edge, one cycle after the request edge
task automatic wait_response(output logic [31:0] data);
  int cycles;
  cycles = 0;
  data   = '0;
  do begin
    @(negedge clk);
    cycles++;
  end while (!dmi_rsp_valid_o && cycles < Timeout);
  if (!dmi_rsp_valid_o) begin
    timeout_errors++;
    $display("No DMI response within %0d cycles at %0t", Timeout, $time);
  end else begin
    data = dmi_rdata_o;
    check_value(32'(cycles), 32'd1, "DMI response latency");
  end
endtask

task automatic dmi_write(input logic [6:0] addr, input logic [31:0] data);
  logic [31:0] rsp;
  drive_request(1'b1, addr, data);
  drive_idle();
  wait_response(rsp);
  check_value(rsp, 32'h0, "write response data");
endtask

task automatic dmi_read(input logic [6:0] addr, output logic [31:0] data);
  drive_request(1'b0, addr, '0);
  drive_idle();
  wait_response(data);
endtask

task automatic wait_not_busy();
  logic [31:0] sbcs;
  int          polls;
  polls = 0;
  do begin
    dmi_read(dbg_pkg::AddrSbcs, sbcs);
    polls++;
  end while (sbcs[dbg_pkg::SbcsBusyBit] && polls < PollLimit);
  if (sbcs[dbg_pkg::SbcsBusyBit]) begin
    timeout_errors++;
    $display("Port still busy after %0d SBCS polls at %0t", PollLimit, $time);
  end
endtask

//////////////////////////////////////////////////////////////////////
// Register access with model update
//////////////////////////////////////////////////////////////////////

task automatic check_reg(input logic [6:0] addr, input logic [31:0] exp,
                         input string what);
  logic [31:0] val;
  dmi_read(addr, val);
  check_value(val, exp, what);
endtask

task automatic advance_address();
  if (autoincr_model) begin
    sbaddr_model = (sbaddr_model + 1) % MemWords;
  end
endtask

task automatic write_sbcs(input logic [31:0] val);
  dmi_write(dbg_pkg::AddrSbcs, val);
  autoincr_model   = val[dbg_pkg::SbcsAutoIncrBit];
  readondata_model = val[dbg_pkg::SbcsReadOnDataBit];
endtask

task automatic write_sbaddr(input int unsigned addr);
  dmi_write(dbg_pkg::AddrSbAddr, 32'(addr));
  sbaddr_model = addr % MemWords;
endtask

task automatic write_sbdata(input logic [31:0] data);
  dmi_write(dbg_pkg::AddrSbData, data);
  ref_mem[sbaddr_model] = data;
  sbdata_model          = data;
  advance_address();
  wait_not_busy();
endtask

// Returns the held word; with read-on-data the next word is fetched
task automatic read_sbdata_check();
  logic [31:0] val;
  dmi_read(dbg_pkg::AddrSbData, val);
  check_value(val, sbdata_model, "SBDATA read");
  if (readondata_model) begin
    sbdata_model = ref_mem[sbaddr_model];
    advance_address();
  end
  wait_not_busy();
endtask

//////////////////////////////////////////////////////////////////////
// Directed tests
//////////////////////////////////////////////////////////////////////

task automatic test_reset_state();
  check_reg(dbg_pkg::AddrSbcs, 32'h0, "SBCS after reset");
  check_reg(dbg_pkg::AddrSbAddr, 32'h0, "SBADDR after reset");
  check_reg(dbg_pkg::AddrSbData, 32'h0, "SBDATA after reset");
endtask

task automatic test_write_burst();
  write_sbcs(AutoIncr);
  write_sbaddr(10);
  repeat (8) write_sbdata(lcg_next());
  check_reg(dbg_pkg::AddrSbAddr, 32'd18, "SBADDR after write burst");
endtask

task automatic test_read_on_data();
  write_sbcs(AutoIncr | ReadOnData);
  write_sbaddr(10);
  // Priming read without increment
  write_sbcs(ReadOnData);
  write_sbaddr(10);
  read_sbdata_check();
  write_sbcs(AutoIncr | ReadOnData);
  repeat (8) read_sbdata_check();
endtask

task automatic test_busy_error();
  logic [31:0] first;
  logic [31:0] second;
  first  = lcg_next();
  second = lcg_next();
  write_sbcs(32'h0);
  write_sbaddr(40);
  // Second write lands while the first is in flight
  drive_request(1'b1, dbg_pkg::AddrSbData, first);
  drive_request(1'b1, dbg_pkg::AddrSbData, second);
  drive_idle();
  ref_mem[40]  = first;
  sbdata_model = first;
  wait_not_busy();
  check_reg(dbg_pkg::AddrSbcs, BusyErr, "SBCS after colliding write");
  write_sbcs(ReadOnData);
  write_sbaddr(40);
  read_sbdata_check();
  read_sbdata_check();
  write_sbcs(BusyErr);
  check_reg(dbg_pkg::AddrSbcs, 32'h0, "SBCS after busy-error clear");
endtask

task automatic test_address_wrap();
  write_sbcs(AutoIncr);
  write_sbaddr(MemWords - 1);
  write_sbdata(lcg_next());
  check_reg(dbg_pkg::AddrSbAddr, 32'h0, "SBADDR after wrap");
  write_sbcs(ReadOnData);
  write_sbaddr(MemWords - 1);
  read_sbdata_check();
  read_sbdata_check();
endtask

// File: verification/tb_dbg_sba.sv
/*
 * Testbench for the debug system-bus access port.
 * Drives DMI requests into dbg_sba_top and checks the responses against
 * a reference memory and a model of SBADDR, SBDATA and the SBCS controls.
 */

`timescale 1ns/10ps
`default_nettype none

module tb_dbg_sba;

  localparam int MemWords  = 256;
  // Cycles allowed for one DMI response
  localparam int Timeout   = 20;
  // SBCS polls allowed while waiting for busy to clear
  localparam int PollLimit = 20;

  localparam logic [31:0] AutoIncr   = 32'h1 << dbg_pkg::SbcsAutoIncrBit;
  localparam logic [31:0] ReadOnData = 32'h1 << dbg_pkg::SbcsReadOnDataBit;
  localparam logic [31:0] BusyErr    = 32'h1 << dbg_pkg::SbcsBusyErrBit;

  logic                             clk;
  logic                             rst_n_i;
  logic                             dmi_req_valid_i;
  logic                             dmi_write_i;
  logic [dbg_pkg::DmiAddrWidth-1:0] dmi_addr_i;
  logic [dbg_pkg::DataWidth-1:0]    dmi_wdata_i;
  logic                             dmi_rsp_valid_o;
  logic [dbg_pkg::DataWidth-1:0]    dmi_rdata_o;

  int unsigned checks_run;
  int unsigned check_errors;
  int unsigned timeout_errors;
  logic [31:0] lcg_state;

  // Reference state
  logic [31:0] ref_mem [MemWords];
  int unsigned sbaddr_model;
  logic [31:0] sbdata_model;
  logic        autoincr_model;
  logic        readondata_model;

  dbg_sba_top dut0 (
    .clk             ( clk             ),
    .rst_n_i         ( rst_n_i         ),
    .dmi_req_valid_i ( dmi_req_valid_i ),
    .dmi_write_i     ( dmi_write_i     ),
    .dmi_addr_i      ( dmi_addr_i      ),
    .dmi_wdata_i     ( dmi_wdata_i     ),
    .dmi_rsp_valid_o ( dmi_rsp_valid_o ),
    .dmi_rdata_o     ( dmi_rdata_o     )
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;

  // Numerical Recipes constants
  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  `include "tb_dbg_tasks.svh"

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    rst_n_i          = 1'b0;
    dmi_req_valid_i  = 1'b0;
    dmi_write_i      = 1'b0;
    dmi_addr_i       = '0;
    dmi_wdata_i      = '0;
    checks_run       = 0;
    check_errors     = 0;
    timeout_errors   = 0;
    lcg_state        = 32'd1;
    sbaddr_model     = 0;
    sbdata_model     = '0;
    autoincr_model   = 1'b0;
    readondata_model = 1'b0;

    repeat (4) @(posedge clk);
    rst_n_i <= 1'b1;

    test_reset_state();
    test_write_burst();
    test_read_on_data();
    test_busy_error();
    test_address_wrap();

    $display("Checks run: %0d, failed: %0d, timeouts: %0d",
             checks_run, check_errors, timeout_errors);
    if (check_errors == 0 && timeout_errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: source/dbg_sba_top.sv
/*
 * Debug system-bus access port, top level.
 * A host drives DMI request strobes; SBCS, SBADDR and SBDATA give access
 * to an on-chip word memory with a fixed access latency.
 */

`timescale 1ns/10ps
`default_nettype none

module dbg_sba_top #(
  parameter int unsigned MemWords   = 256,
  parameter int unsigned MemLatency = 3
) (
  input  logic                             clk,
  input  logic                             rst_n_i,
  input  logic                             dmi_req_valid_i,
  input  logic                             dmi_write_i,
  input  logic [dbg_pkg::DmiAddrWidth-1:0] dmi_addr_i,
  input  logic [dbg_pkg::DataWidth-1:0]    dmi_wdata_i,
  output logic                             dmi_rsp_valid_o,
  output logic [dbg_pkg::DataWidth-1:0]    dmi_rdata_o
);

  localparam int AddrWidth = $clog2(MemWords);

  logic                          acc_start;
  logic                          acc_write;
  logic                          acc_done;
  logic                          busy;
  logic                          tmr_start;
  logic                          tmr_done;
  logic                          mem_we;
  logic                          mem_re;
  logic [AddrWidth-1:0]          mem_addr;
  logic [dbg_pkg::DataWidth-1:0] mem_wdata;
  logic [dbg_pkg::DataWidth-1:0] mem_rdata;

  sba_regs #(
    .MemWords        ( MemWords        )
  ) regs0 (
    .clk             ( clk             ),
    .rst_n_i         ( rst_n_i         ),
    .dmi_req_valid_i ( dmi_req_valid_i ),
    .dmi_write_i     ( dmi_write_i     ),
    .dmi_addr_i      ( dmi_addr_i      ),
    .dmi_wdata_i     ( dmi_wdata_i     ),
    .dmi_rsp_valid_o ( dmi_rsp_valid_o ),
    .dmi_rdata_o     ( dmi_rdata_o     ),
    .busy_i          ( busy            ),
    .acc_done_i      ( acc_done        ),
    .mem_rdata_i     ( mem_rdata       ),
    .acc_start_o     ( acc_start       ),
    .acc_write_o     ( acc_write       ),
    .mem_addr_o      ( mem_addr        ),
    .mem_wdata_o     ( mem_wdata       )
  );

  sba_fsm #(
    .MemLatency  ( MemLatency )
  ) fsm0 (
    .clk         ( clk        ),
    .rst_n_i     ( rst_n_i    ),
    .acc_start_i ( acc_start  ),
    .acc_write_i ( acc_write  ),
    .tmr_done_i  ( tmr_done   ),
    .tmr_start_o ( tmr_start  ),
    .mem_we_o    ( mem_we     ),
    .mem_re_o    ( mem_re     ),
    .busy_o      ( busy       ),
    .acc_done_o  ( acc_done   )
  );

  access_timer #(
    .MemLatency ( MemLatency )
  ) timer0 (
    .clk        ( clk        ),
    .rst_n_i    ( rst_n_i    ),
    .start_i    ( tmr_start  ),
    .done_o     ( tmr_done   )
  );

  word_mem #(
    .MemWords ( MemWords  )
  ) mem0 (
    .clk      ( clk       ),
    .we_i     ( mem_we    ),
    .re_i     ( mem_re    ),
    .addr_i   ( mem_addr  ),
    .wdata_i  ( mem_wdata ),
    .rdata_o  ( mem_rdata )
  );

endmodule

`default_nettype wire

// File: source/sba_regs.sv
/*
 * DMI register block for the system-bus access port.
 * Decodes single-cycle DMI requests, holds SBCS, SBADDR and SBDATA,
 * answers every request one cycle later and starts bus accesses.
 * Requests that collide with a running access are dropped and flagged.
 */

`timescale 1ns/10ps
`default_nettype none

module sba_regs #(
  parameter int unsigned MemWords = 256
) (
  input  logic                                clk,
  input  logic                                rst_n_i,
  input  logic                                dmi_req_valid_i,
  input  logic                                dmi_write_i,
  input  logic [dbg_pkg::DmiAddrWidth-1:0]    dmi_addr_i,
  input  logic [dbg_pkg::DataWidth-1:0]       dmi_wdata_i,
  output logic                                dmi_rsp_valid_o,
  output logic [dbg_pkg::DataWidth-1:0]       dmi_rdata_o,
  input  logic                                busy_i,
  input  logic                                acc_done_i,
  input  logic [dbg_pkg::DataWidth-1:0]       mem_rdata_i,
  output logic                                acc_start_o,
  output logic                                acc_write_o,
  output logic [$clog2(MemWords)-1:0]         mem_addr_o,
  output logic [dbg_pkg::DataWidth-1:0]       mem_wdata_o
);

  localparam int AddrWidth = $clog2(MemWords);

  logic                          busyerr_q;
  logic                          autoincr_q;
  logic                          readondata_q;
  logic [AddrWidth-1:0]          sbaddr_q;
  logic [dbg_pkg::DataWidth-1:0] sbdata_q;
  logic                          rd_pend_q;
  logic                          rsp_valid_q;
  logic [dbg_pkg::DataWidth-1:0] rdata_q;

  logic                          req_rd;
  logic                          req_wr;
  logic                          wr_sbcs;
  logic                          wr_addr;
  logic                          wr_data;
  logic                          rd_data;
  logic                          start_req;
  logic                          conflict;
  logic [dbg_pkg::DataWidth-1:0] sbcs_val;
  logic [dbg_pkg::DataWidth-1:0] rd_val;

  //////////////////////////////////////////////////////////////////////
  // Request decode
  //////////////////////////////////////////////////////////////////////

  assign req_rd  = dmi_req_valid_i && !dmi_write_i;
  assign req_wr  = dmi_req_valid_i && dmi_write_i;
  assign wr_sbcs = req_wr && (dmi_addr_i == dbg_pkg::AddrSbcs);
  assign wr_addr = req_wr && (dmi_addr_i == dbg_pkg::AddrSbAddr);
  assign wr_data = req_wr && (dmi_addr_i == dbg_pkg::AddrSbData);
  assign rd_data = req_rd && (dmi_addr_i == dbg_pkg::AddrSbData);

  // Anything that needs the bus
  assign start_req = wr_data || (rd_data && readondata_q);
  // SBADDR is also locked during an access
  assign conflict  = busy_i && (start_req || wr_addr);

  assign acc_start_o = start_req && !busy_i;
  assign acc_write_o = wr_data;

  assign mem_addr_o  = sbaddr_q;
  assign mem_wdata_o = sbdata_q;

  //////////////////////////////////////////////////////////////////////
  // Registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      busyerr_q    <= 1'b0;
      autoincr_q   <= 1'b0;
      readondata_q <= 1'b0;
      sbaddr_q     <= '0;
      sbdata_q     <= '0;
      rd_pend_q    <= 1'b0;
      rsp_valid_q  <= 1'b0;
    end else begin
      rsp_valid_q <= dmi_req_valid_i;

      if (wr_sbcs) begin
        autoincr_q   <= dmi_wdata_i[dbg_pkg::SbcsAutoIncrBit];
        readondata_q <= dmi_wdata_i[dbg_pkg::SbcsReadOnDataBit];
      end

      // Sticky, cleared by writing a one
      if (conflict) begin
        busyerr_q <= 1'b1;
      end else if (wr_sbcs && dmi_wdata_i[dbg_pkg::SbcsBusyErrBit]) begin
        busyerr_q <= 1'b0;
      end

      if (acc_start_o) begin
        rd_pend_q <= !wr_data;
      end

      // Host writes only land when idle
      if (wr_addr && !busy_i) begin
        sbaddr_q <= dmi_wdata_i[AddrWidth-1:0];
      end else if (acc_done_i && autoincr_q) begin
        sbaddr_q <= sbaddr_q + 1'b1;
      end

      if (wr_data && !busy_i) begin
        sbdata_q <= dmi_wdata_i;
      end else if (acc_done_i && rd_pend_q) begin
        sbdata_q <= mem_rdata_i;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Response
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    sbcs_val = '0;
    sbcs_val[dbg_pkg::SbcsBusyErrBit]    = busyerr_q;
    sbcs_val[dbg_pkg::SbcsBusyBit]       = busy_i;
    sbcs_val[dbg_pkg::SbcsAutoIncrBit]   = autoincr_q;
    sbcs_val[dbg_pkg::SbcsReadOnDataBit] = readondata_q;
  end

  always_comb begin
    case (dmi_addr_i)
      dbg_pkg::AddrSbcs:   rd_val = sbcs_val;
      dbg_pkg::AddrSbAddr: rd_val = dbg_pkg::DataWidth'(sbaddr_q);
      dbg_pkg::AddrSbData: rd_val = sbdata_q;
      default:             rd_val = '0;
    endcase
  end

  // Value as seen at the request edge, zero for writes
  always_ff @(posedge clk) begin
    rdata_q <= req_rd ? rd_val : '0;
  end

  assign dmi_rsp_valid_o = rsp_valid_q;
  assign dmi_rdata_o     = rdata_q;

  a_rsp_follows_req : assert property (
    @(posedge clk) disable iff (!rst_n_i)
    dmi_req_valid_i |=> dmi_rsp_valid_o
  ) else $error("sba_regs: missing DMI response");

endmodule

`default_nettype wire

// File: source/word_mem.sv
/*
 * On-chip word memory behind the system bus.
 * Write takes effect at the clock edge; a read registers the word into
 * rdata_o, which holds until the next read strobe.
 */

`timescale 1ns/10ps
`default_nettype none

module word_mem #(
  parameter int unsigned MemWords = 256
) (
  input  logic                            clk,
  input  logic                            we_i,
  input  logic                            re_i,
  input  logic [$clog2(MemWords)-1:0]     addr_i,
  input  logic [dbg_pkg::DataWidth-1:0]   wdata_i,
  output logic [dbg_pkg::DataWidth-1:0]   rdata_o
);

  logic [dbg_pkg::DataWidth-1:0] mem_q [MemWords];

  //////////////////////////////////////////////////////////////////////
  // Array
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (we_i) begin
      mem_q[addr_i] <= wdata_i;
    end
  end

  // One cycle read latency
  always_ff @(posedge clk) begin
    if (re_i) begin
      rdata_o <= mem_q[addr_i];
    end
  end

endmodule

`default_nettype wire

// File: source/sba_fsm.sv
/*
 * Sequencer for system-bus accesses.
 * Takes a start strobe from the register block, issues one memory strobe,
 * runs the latency timer and reports busy and completion back.
 * The caller guarantees that starts only arrive while idle.
 */

`timescale 1ns/10ps
`default_nettype none

module sba_fsm #(
  parameter int unsigned MemLatency = 3
) (
  input  logic clk,
  input  logic rst_n_i,
  input  logic acc_start_i,
  input  logic acc_write_i,
  input  logic tmr_done_i,
  output logic tmr_start_o,
  output logic mem_we_o,
  output logic mem_re_o,
  output logic busy_o,
  output logic acc_done_o
);

  typedef enum logic [1:0] {
    IDLE,
    ISSUE,
    WAIT
  } state_e;

  state_e state_q;
  state_e state_d;
  logic   write_q;

  //////////////////////////////////////////////////////////////////////
  // State register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      state_q <= IDLE;
      write_q <= 1'b0;
    end else begin
      state_q <= state_d;
      // Access type is fixed for the whole transfer
      if (state_q == IDLE && acc_start_i) begin
        write_q <= acc_write_i;
      end
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (acc_start_i) begin
          state_d = ISSUE;
        end
      end
      ISSUE: begin
        state_d = WAIT;
      end
      WAIT: begin
        if (tmr_done_i) begin
          state_d = IDLE;
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Outputs
  //////////////////////////////////////////////////////////////////////

  // One memory strobe per access with the timer started alongside
  assign mem_we_o    = (state_q == ISSUE) && write_q;
  assign mem_re_o    = (state_q == ISSUE) && !write_q;
  assign tmr_start_o = (state_q == ISSUE);

  assign busy_o     = (state_q != IDLE);
  // Registers update on the edge that closes the last busy cycle
  assign acc_done_o = (state_q == WAIT) && tmr_done_i;

  //////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////

  a_start_when_idle : assert property (
    @(posedge clk) disable iff (!rst_n_i)
    acc_start_i |-> (state_q == IDLE)
  ) else $error("sba_fsm: access start while busy");

  // Exactly one strobe of the requested type right after a start
  a_one_strobe : assert property (
    @(posedge clk) disable iff (!rst_n_i)
    acc_start_i |=> (mem_we_o == $past(acc_write_i)) &&
                    (mem_re_o == !$past(acc_write_i))
  ) else $error("sba_fsm: wrong memory strobe after start");

  // Timer round trip matches the configured latency
  a_latency : assert property (
    @(posedge clk) disable iff (!rst_n_i)
    tmr_start_o |-> ##MemLatency tmr_done_i
  ) else $error("sba_fsm: timer done off the latency");

endmodule

`default_nettype wire

// File: source/access_timer.sv
/*
 * Latency timer for one system-bus access.
 * Loads MemLatency on start_i and counts down; done_o marks the last
 * cycle of the access window, MemLatency cycles after start_i.
 */

`timescale 1ns/10ps
`default_nettype none

module access_timer #(
  parameter int unsigned MemLatency = 3
) (
  input  logic clk,
  input  logic rst_n_i,
  input  logic start_i,
  output logic done_o
);

  localparam int CntWidth = $clog2(MemLatency + 1);

  logic [CntWidth-1:0] cnt_q;

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      cnt_q <= '0;
    end else if (start_i) begin
      cnt_q <= CntWidth'(MemLatency);
    end else if (cnt_q != '0) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  // Count about to reach zero
  assign done_o = (cnt_q == CntWidth'(1));

  // A new access may only be timed once the previous one has expired
  a_no_restart : assert property (
    @(posedge clk) disable iff (!rst_n_i)
    start_i |-> (cnt_q == '0)
  ) else $error("access_timer: start while counting");

endmodule

`default_nettype wire

// File: source/dbg_pkg.sv
/*
 * Shared constants for the debug system-bus access port.
 * Holds the DMI register map, the SBCS bit layout and the bus word width.
 * Modules refer to these by scoped name.
 */

`default_nettype none

package dbg_pkg;

  //////////////////////////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////////////////////////

  // DMI and system bus word
  localparam int DataWidth    = 32;
  localparam int DmiAddrWidth = 7;

  //////////////////////////////////////////////////////////////////////
  // DMI register addresses
  //////////////////////////////////////////////////////////////////////

  localparam logic [DmiAddrWidth-1:0] AddrSbcs   = 7'h38;
  localparam logic [DmiAddrWidth-1:0] AddrSbAddr = 7'h39;
  localparam logic [DmiAddrWidth-1:0] AddrSbData = 7'h3C;

  //////////////////////////////////////////////////////////////////////
  // SBCS bit positions
  //////////////////////////////////////////////////////////////////////

  // Sticky, write 1 to clear
  localparam int SbcsBusyErrBit    = 22;
  // Read-only view of the access FSM
  localparam int SbcsBusyBit       = 21;
  // Writable controls
  localparam int SbcsAutoIncrBit   = 16;
  localparam int SbcsReadOnDataBit = 15;

endpackage

`default_nettype wire
